// ==== common/boot_params.svh ====
`ifndef BOOT_PARAMS_SVH
`define BOOT_PARAMS_SVH

// words copied from flash to sram after reset
`define BOOT_WORDS 64

// raw_clk cycles of output enable before the flash data is sampled
`define FLASH_WAIT 3

// flash word address, bits [22:1] of the byte address
`define FLASH_AW 22

// sram word address
`define RAM_AW 18

// data bus width of both memories
`define DATA_W 16

`endif

// ==== common/boot_pkg.sv ====
`default_nettype none
`include "boot_params.svh"

package boot_pkg;

	// one sram request, rd or wr strobed for a single cycle
	typedef struct packed {
		logic rd;
		logic wr;
		logic [`RAM_AW-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} mem_req_t;

	// sram answer, rdata only meaningful with done on a read
	typedef struct packed {
		logic done;
		logic [`DATA_W-1:0] rdata;
	} mem_rsp_t;

	// result of one flash word read
	typedef struct packed {
		logic ready;
		logic [`DATA_W-1:0] data;
	} flash_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/seg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_decoder (
	input wire [3:0] digit,
	output logic [6:0] segments
);

	// segments[6:0] = g f e d c b a, low lights the segment
	always_comb begin
		case (digit)
			4'h0: segments = 7'h40;
			4'h1: segments = 7'h79;
			4'h2: segments = 7'h24;
			4'h3: segments = 7'h30;
			4'h4: segments = 7'h19;
			4'h5: segments = 7'h12;
			4'h6: segments = 7'h02;
			4'h7: segments = 7'h78;
			4'h8: segments = 7'h00;
			4'h9: segments = 7'h10;
			4'ha: segments = 7'h08;
			4'hb: segments = 7'h03;
			4'hc: segments = 7'h46;
			4'hd: segments = 7'h21;
			4'he: segments = 7'h06;
			default: segments = 7'h0e;
		endcase
	end

endmodule

`default_nettype wire

// ==== boot/flash_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module flash_ctrl (
	input wire raw_clk,
	input wire rst,
	input wire flash_read,
	input wire [`FLASH_AW-1:0] flash_word_addr,
	input wire [`DATA_W-1:0] flash_data,
	output logic [`FLASH_AW:0] flash_addr,
	output logic flash_ce,
	output logic flash_oe,
	output boot_pkg::flash_rsp_t flash_rsp
);

	localparam int CNT_W = $clog2(`FLASH_WAIT + 2);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`FLASH_WAIT);

	logic busy;
	logic [CNT_W-1:0] wait_cnt;
	logic ready_q;
	logic [`DATA_W-1:0] data_q;
	logic sample;

	// final cycle of the access, bus is sampled at its end
	assign sample = busy && (wait_cnt == LAST_CNT);

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			busy <= 1'b0;
			wait_cnt <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= 1'b0;
			if (!busy) begin
				if (flash_read) begin
					busy <= 1'b1;
					wait_cnt <= '0;
				end
			end else if (sample) begin
				busy <= 1'b0;
				ready_q <= 1'b1;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge raw_clk) begin
		// byte address, word mode ignores bit 0
		if (!busy && flash_read) begin
			flash_addr <= {flash_word_addr, 1'b0};
		end
		if (sample) begin
			data_q <= flash_data;
		end
	end

	assign flash_ce = ~busy;
	assign flash_oe = ~busy;

	assign flash_rsp.ready = ready_q;
	assign flash_rsp.data = data_q;

endmodule

`default_nettype wire

// ==== boot/bootloader.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module bootloader (
	input wire raw_clk,
	input wire rst,
	input wire boot_pkg::flash_rsp_t flash_rsp,
	input wire boot_pkg::mem_rsp_t init_rsp,
	output logic flash_read,
	output logic [`FLASH_AW-1:0] flash_word_addr,
	output boot_pkg::mem_req_t init_req,
	output logic boot_done,
	output logic [14:0] words_copied,
	output logic [`DATA_W-1:0] last_data
);

	typedef enum logic [2:0] {
		S_READ,
		S_WAIT_FLASH,
		S_WRITE,
		S_WAIT_RAM,
		S_DONE
	} state_t;

	state_t state;
	logic [14:0] word_cnt;

	// one word per pass: flash read, then sram write
	always_ff @(posedge raw_clk) begin
		if (rst) begin
			state <= S_READ;
			word_cnt <= '0;
		end else begin
			case (state)
				S_READ: begin
					state <= S_WAIT_FLASH;
				end
				S_WAIT_FLASH: begin
					if (flash_rsp.ready) begin
						state <= S_WRITE;
					end
				end
				S_WRITE: begin
					state <= S_WAIT_RAM;
				end
				S_WAIT_RAM: begin
					if (init_rsp.done) begin
						word_cnt <= word_cnt + 1'b1;
						// last word written, hand the sram over
						if (word_cnt == 15'(`BOOT_WORDS - 1)) begin
							state <= S_DONE;
						end else begin
							state <= S_READ;
						end
					end
				end
				default: begin
					state <= S_DONE;
				end
			endcase
		end
	end

	// flash word kept for the sram write and the display
	always_ff @(posedge raw_clk) begin
		if (state == S_WAIT_FLASH && flash_rsp.ready) begin
			last_data <= flash_rsp.data;
		end
	end

	assign flash_read = (state == S_READ);
	assign flash_word_addr = `FLASH_AW'(word_cnt);

	assign init_req.rd = 1'b0;
	assign init_req.wr = (state == S_WRITE);
	assign init_req.addr = `RAM_AW'(word_cnt);
	assign init_req.wdata = last_data;

	assign boot_done = (state == S_DONE);
	assign words_copied = word_cnt;

endmodule

`default_nettype wire

// ==== verilog/sram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module sram_ctrl (
	input wire raw_clk,
	input wire rst,
	input wire boot_done,
	input wire boot_pkg::mem_req_t init_req,
	input wire boot_pkg::mem_req_t exe_req,
	output boot_pkg::mem_rsp_t init_rsp,
	output boot_pkg::mem_rsp_t exe_rsp,
	output logic [`RAM_AW-1:0] ram_addr,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	inout wire [`DATA_W-1:0] ram_data
);

	// access and strobe are the two cycles with the chip enabled
	typedef enum logic [1:0] {
		S_IDLE,
		S_ACCESS,
		S_STROBE,
		S_DONE
	} state_t;

	state_t state;
	boot_pkg::mem_req_t req;
	logic accept;
	logic active;
	logic is_write;
	logic owner_exe;
	logic [`DATA_W-1:0] wdata_q;
	logic [`DATA_W-1:0] rdata_q;

	// boot side owns the sram until the copy is over
	assign req = boot_done ? exe_req : init_req;

	assign accept = (state == S_IDLE || state == S_DONE) && (req.rd || req.wr);
	assign active = (state == S_ACCESS || state == S_STROBE);

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			state <= S_IDLE;
			is_write <= 1'b0;
			owner_exe <= 1'b0;
		end else begin
			case (state)
				S_ACCESS: begin
					state <= S_STROBE;
				end
				S_STROBE: begin
					state <= S_DONE;
				end
				default: begin
					if (accept) begin
						state <= S_ACCESS;
						is_write <= req.wr;
						owner_exe <= boot_done;
					end else begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge raw_clk) begin
		if (accept) begin
			ram_addr <= req.addr;
			wdata_q <= req.wdata;
		end
		// read data valid at the end of the second oe cycle
		if (state == S_STROBE && !is_write) begin
			rdata_q <= ram_data;
		end
	end

	assign ram_en = ~active;
	assign ram_oe = ~(active && !is_write);
	assign ram_we = ~(state == S_STROBE && is_write);

	// bus driven only during a write
	assign ram_data = (active && is_write) ? wdata_q : 'z;

	assign init_rsp.done = (state == S_DONE) && !owner_exe;
	assign init_rsp.rdata = rdata_q;
	assign exe_rsp.done = (state == S_DONE) && owner_exe;
	assign exe_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/boot_sys.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module boot_sys (
	input wire raw_clk,
	input wire rst,
	input wire [`DATA_W-1:0] flash_data,
	input wire boot_pkg::mem_req_t exe_req,
	output boot_pkg::mem_rsp_t exe_rsp,
	output logic boot_done,
	output logic [`FLASH_AW:0] flash_addr,
	output logic flash_ce,
	output logic flash_oe,
	output logic flash_we,
	output logic flash_byte,
	output logic flash_vpen,
	output logic flash_rp,
	output logic [`RAM_AW-1:0] ram_addr,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic [6:0] seg1,
	output logic [6:0] seg2,
	output logic [15:0] led,
	inout wire [`DATA_W-1:0] ram_data
);

	logic flash_read;
	logic [`FLASH_AW-1:0] flash_word_addr;
	boot_pkg::flash_rsp_t flash_rsp;
	boot_pkg::mem_req_t init_req;
	boot_pkg::mem_rsp_t init_rsp;
	logic [14:0] words_copied;
	logic [`DATA_W-1:0] last_data;

	bootloader __bootloader (
		.raw_clk(raw_clk),
		.rst(rst),
		.flash_rsp(flash_rsp),
		.init_rsp(init_rsp),
		.flash_read(flash_read),
		.flash_word_addr(flash_word_addr),
		.init_req(init_req),
		.boot_done(boot_done),
		.words_copied(words_copied),
		.last_data(last_data)
	);

	flash_ctrl __flash_ctrl (
		.raw_clk(raw_clk),
		.rst(rst),
		.flash_read(flash_read),
		.flash_word_addr(flash_word_addr),
		.flash_data(flash_data),
		.flash_addr(flash_addr),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.flash_rsp(flash_rsp)
	);

	// read only, word mode, no programming
	assign flash_we = 1'b1;
	assign flash_byte = 1'b1;
	assign flash_vpen = 1'b0;
	assign flash_rp = 1'b1;

	sram_ctrl __sram_ctrl (
		.raw_clk(raw_clk),
		.rst(rst),
		.boot_done(boot_done),
		.init_req(init_req),
		.exe_req(exe_req),
		.init_rsp(init_rsp),
		.exe_rsp(exe_rsp),
		.ram_addr(ram_addr),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.ram_data(ram_data)
	);

	// boot progress on the debug display
	seg_decoder __seg_decoder_1 (
		.digit(flash_addr[4:1]),
		.segments(seg1)
	);

	seg_decoder __seg_decoder_2 (
		.digit(last_data[3:0]),
		.segments(seg2)
	);

	assign led = {boot_done, words_copied};

endmodule

`default_nettype wire

// ==== test/boot_sys_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_sys_assert (
	input wire raw_clk,
	input wire rst,
	input wire ram_en,
	input wire ram_oe,
	input wire ram_we,
	input wire flash_ce,
	input wire flash_oe
);

	int fail_cnt = 0;

	// write strobe and read enable never overlap
	we_oe_exclusive: assert property (@(posedge raw_clk) disable iff (rst) ram_we || ram_oe)
		else begin
			$error("ram_we and ram_oe low in the same cycle");
			fail_cnt++;
		end

	we_single_cycle: assert property (@(posedge raw_clk) disable iff (rst) !ram_we |=> ram_we)
		else begin
			$error("ram_we low for more than one cycle");
			fail_cnt++;
		end

	oe_inside_ce: assert property (@(posedge raw_clk) disable iff (rst) !flash_oe |-> !flash_ce)
		else begin
			$error("flash_oe low while flash_ce high");
			fail_cnt++;
		end

	// every enable idles high out of reset
	idle_after_reset: assert property (@(posedge raw_clk)
			rst |=> (ram_en && ram_oe && ram_we && flash_ce && flash_oe))
		else begin
			$error("enable low right after reset");
			fail_cnt++;
		end

endmodule

bind sram_ctrl boot_sys_assert ram_chk (
	.raw_clk(raw_clk),
	.rst(rst),
	.ram_en(ram_en),
	.ram_oe(ram_oe),
	.ram_we(ram_we),
	.flash_ce(1'b1),
	.flash_oe(1'b1)
);

bind flash_ctrl boot_sys_assert flash_chk (
	.raw_clk(raw_clk),
	.rst(rst),
	.ram_en(1'b1),
	.ram_oe(1'b1),
	.ram_we(1'b1),
	.flash_ce(flash_ce),
	.flash_oe(flash_oe)
);

`default_nettype wire

// ==== test/tb_boot_sys.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module tb_boot_sys;

	localparam int CLK_NS = 40;
	localparam int EXE_PAIRS = 20;
	localparam int BOOT_LIMIT = `BOOT_WORDS * (`FLASH_WAIT + 8);
	localparam int WATCHDOG_CYCLES = BOOT_LIMIT + 2000;
	localparam logic [15:0] FLASH_KEY = 16'h5a3c;

	logic raw_clk;
	logic rst;
	logic scrub;
	boot_pkg::mem_req_t exe_req;
	boot_pkg::mem_rsp_t exe_rsp;
	logic boot_done;
	logic [`DATA_W-1:0] flash_data;
	logic [`FLASH_AW:0] flash_addr;
	logic flash_ce;
	logic flash_oe;
	logic flash_we;
	logic flash_byte;
	logic flash_vpen;
	logic flash_rp;
	logic [`RAM_AW-1:0] ram_addr;
	logic ram_en;
	logic ram_oe;
	logic ram_we;
	logic [6:0] seg1;
	logic [6:0] seg2;
	logic [15:0] led;
	wire [`DATA_W-1:0] ram_data;
	logic [`DATA_W-1:0] sram_mem [0:(1 << `RAM_AW) - 1];
	int value_errs = 0;
	int proto_errs = 0;
	int assert_fails;

	boot_sys dut (
		.raw_clk(raw_clk),
		.rst(rst),
		.flash_data(flash_data),
		.exe_req(exe_req),
		.exe_rsp(exe_rsp),
		.boot_done(boot_done),
		.flash_addr(flash_addr),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.flash_we(flash_we),
		.flash_byte(flash_byte),
		.flash_vpen(flash_vpen),
		.flash_rp(flash_rp),
		.ram_addr(ram_addr),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.seg1(seg1),
		.seg2(seg2),
		.led(led),
		.ram_data(ram_data)
	);

	initial begin
		raw_clk = 1'b0;
		forever #(CLK_NS / 2) raw_clk = ~raw_clk;
	end

	// flash word at word address a is a ^ key
	assign flash_data = (!flash_ce && !flash_oe) ? (flash_addr[16:1] ^ FLASH_KEY) : 16'hffff;

	// async sram model
	assign ram_data = !ram_oe ? sram_mem[ram_addr] : 16'hzzzz;

	// scrub overwrites the boot area with wrong data
	always @(negedge ram_we or posedge scrub) begin
		if (scrub) begin
			for (int a = 0; a < `BOOT_WORDS; a++) begin
				sram_mem[a] = ~(16'(a) ^ FLASH_KEY);
			end
		end else if (!ram_en) begin
			sram_mem[ram_addr] = ram_data;
		end
	end

	task automatic report_value(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		$display("** Error %s: %s expected %h, actual %h", test, what, expected, actual);
		value_errs++;
	endtask

	task automatic report_failure(input string test, input string what);
		$display("%s: %s", test, what);
		proto_errs++;
	endtask

	// active low segments in g f e d c b a order
	function automatic logic [6:0] seg_pattern(input logic [3:0] d);
		case (d)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'ha: return 7'h08;
			4'hb: return 7'h03;
			4'hc: return 7'h46;
			4'hd: return 7'h21;
			4'he: return 7'h06;
			default: return 7'h0e;
		endcase
	endfunction

	task automatic apply_reset();
		@(posedge raw_clk);
		rst <= 1'b1;
		repeat (16) @(posedge raw_clk);
		rst <= 1'b0;
	endtask

	// one strobe on the exe port with done due three cycles later
	task automatic exe_access(input string test, input logic wr, input logic [17:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata);
		int cycles;
		@(posedge raw_clk);
		exe_req.rd <= !wr;
		exe_req.wr <= wr;
		exe_req.addr <= addr;
		exe_req.wdata <= wdata;
		@(posedge raw_clk);
		exe_req.rd <= 1'b0;
		exe_req.wr <= 1'b0;
		cycles = 1;
		@(negedge raw_clk);
		while (!exe_rsp.done && cycles < 20) begin
			@(negedge raw_clk);
			cycles++;
		end
		rdata = exe_rsp.rdata;
		if (!exe_rsp.done) begin
			report_failure(test, "exe request never answered with done");
		end else if (cycles != 3) begin
			report_value(test, "done latency", 32'd3, cycles);
		end
	endtask

	task automatic wait_for_boot(input string test);
		int cycles;
		cycles = 0;
		@(negedge raw_clk);
		if (led[15] != 1'b0) begin
			report_value(test, "led[15] during boot", 32'd0, 32'(led[15]));
		end
		while (!boot_done && cycles < BOOT_LIMIT) begin
			@(negedge raw_clk);
			cycles++;
		end
		if (!boot_done) begin
			report_failure(test, "boot_done did not rise");
		end
	endtask

	task automatic compare_boot_image(input string test);
		logic [15:0] rdata;
		logic [15:0] expected;
		for (int i = 0; i < `BOOT_WORDS; i++) begin
			expected = 16'(i) ^ FLASH_KEY;
			exe_access(test, 1'b0, 18'(i), 16'h0000, rdata);
			if (rdata != expected) begin
				report_value(test, $sformatf("sram[%0d]", i), 32'(expected), 32'(rdata));
			end
		end
	endtask

	task automatic verify_boot_copy();
		wait_for_boot("boot_copy");
		compare_boot_image("boot_copy");
	endtask

	task automatic check_led_status();
		@(negedge raw_clk);
		if (led[15] != 1'b1) begin
			report_value("boot_status", "led[15]", 32'd1, 32'(led[15]));
		end
		if (led[14:0] != 15'(`BOOT_WORDS)) begin
			report_value("boot_status", "led[14:0]", 32'(`BOOT_WORDS), 32'(led[14:0]));
		end
	endtask

	// unused flash controls parked inactive, byte pin high for word mode
	task automatic check_flash_pins();
		@(negedge raw_clk);
		if (flash_we != 1'b1) begin
			report_value("flash_pins", "flash_we", 32'd1, 32'(flash_we));
		end
		if (flash_byte != 1'b1) begin
			report_value("flash_pins", "flash_byte", 32'd1, 32'(flash_byte));
		end
		if (flash_vpen != 1'b0) begin
			report_value("flash_pins", "flash_vpen", 32'd0, 32'(flash_vpen));
		end
		if (flash_rp != 1'b1) begin
			report_value("flash_pins", "flash_rp", 32'd1, 32'(flash_rp));
		end
	endtask

	task automatic exe_roundtrip();
		logic [15:0] shadow [logic [17:0]];
		logic [17:0] addr_q [$];
		logic [17:0] addr;
		logic [15:0] data;
		logic [15:0] rdata;
		for (int i = 0; i < EXE_PAIRS; i++) begin
			addr = 18'(`BOOT_WORDS + ($urandom % ((1 << `RAM_AW) - `BOOT_WORDS)));
			data = 16'($urandom);
			shadow[addr] = data;
			addr_q.push_back(addr);
			exe_access("exe_access", 1'b1, addr, data, rdata);
		end
		foreach (addr_q[i]) begin
			exe_access("exe_access", 1'b0, addr_q[i], 16'h0000, rdata);
			if (rdata != shadow[addr_q[i]]) begin
				report_value("exe_access", $sformatf("read %h", addr_q[i]),
					32'(shadow[addr_q[i]]), 32'(rdata));
			end
		end
	endtask

	task automatic display_check();
		logic [15:0] last_word;
		logic [6:0] exp_seg1;
		logic [6:0] exp_seg2;
		last_word = 16'(`BOOT_WORDS - 1) ^ FLASH_KEY;
		exp_seg1 = seg_pattern(4'(`BOOT_WORDS - 1));
		exp_seg2 = seg_pattern(last_word[3:0]);
		@(negedge raw_clk);
		if (seg1 != exp_seg1) begin
			report_value("display", "seg1", 32'(exp_seg1), 32'(seg1));
		end
		if (seg2 != exp_seg2) begin
			report_value("display", "seg2", 32'(exp_seg2), 32'(seg2));
		end
	endtask

	task automatic reset_mid_boot();
		int cycles;
		apply_reset();
		cycles = 0;
		@(negedge raw_clk);
		while (led[14:0] < 15'(`BOOT_WORDS / 4) && cycles < BOOT_LIMIT) begin
			@(negedge raw_clk);
			cycles++;
		end
		// second reset lands in the middle of the copy
		@(posedge raw_clk);
		rst <= 1'b1;
		@(posedge raw_clk);
		scrub <= 1'b1;
		@(posedge raw_clk);
		scrub <= 1'b0;
		repeat (14) @(posedge raw_clk);
		rst <= 1'b0;
		cycles = 0;
		@(negedge raw_clk);
		while (flash_ce && cycles < 20) begin
			@(negedge raw_clk);
			cycles++;
		end
		if (flash_ce) begin
			report_failure("reset_mid_boot", "no flash access started after reset");
		end else if (flash_addr != '0) begin
			report_value("reset_mid_boot", "first flash_addr", 32'd0, 32'(flash_addr));
		end
		wait_for_boot("reset_mid_boot");
		compare_boot_image("reset_mid_boot");
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge raw_clk);
		$display("watchdog: run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h26b4_5148));
		rst = 1'b1;
		scrub = 1'b0;
		exe_req = '0;
		apply_reset();
		verify_boot_copy();
		check_led_status();
		check_flash_pins();
		exe_roundtrip();
		display_check();
		reset_mid_boot();
		assert_fails = dut.__sram_ctrl.ram_chk.fail_cnt;
		assert_fails += dut.__flash_ctrl.flash_chk.fail_cnt;
		$display("errors: %0d value, %0d protocol, %0d assertion",
			value_errs, proto_errs, assert_fails);
		if (value_errs + proto_errs + assert_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/boot_pkg.sv
verilog/seg_decoder.sv
boot/flash_ctrl.sv
boot/bootloader.sv
verilog/sram_ctrl.sv
verilog/boot_sys.sv
test/boot_sys_assert.sv
test/tb_boot_sys.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_boot_sys
FILELIST := vlog.f
RUN_ARGS := +verilator+error+limit+100

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS     := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
